/* src/host_bridge_pkg.sv */
package host_bridge_pkg;

  // ****************************************
  // Host stream types
  // ****************************************

  // One word of the host write and read streams
  typedef logic [31:0] host_word_t;

  // Number of data words in one batch, marker excluded
  typedef logic [15:0] msg_count_t;

  // All-ones word that closes a batch
  localparam host_word_t END_MARKER = '1;

  // ****************************************
  // Buffer sizes
  // ****************************************

  // Host to FPGA stream
  localparam int WR_FIFO_DEPTH = 16;

  // Echo of every host word back to the host
  localparam int LOOP_FIFO_DEPTH = 16;

  // Batch count replies
  localparam int RD_FIFO_DEPTH = 4;

endpackage

/* src/msg_fifo.sv */
module msg_fifo #(
  parameter int depth = 16
) (
  input  logic                        bus_clk,
  input  logic                        rst,
  input  logic                        wr_en,
  input  host_bridge_pkg::host_word_t din,
  input  logic                        rd_en,
  output host_bridge_pkg::host_word_t dout,
  output logic                        full,
  output logic                        empty
);
  import host_bridge_pkg::*;

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  host_word_t       mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_wr;
  logic             do_rd;

  // Requests past the limits are dropped here
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // First word falls through to the output
  assign dout  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == cnt_w'(depth));

  always_ff @(posedge bus_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  // ****************************************
  // Pointers and occupancy
  // ****************************************
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* src/host_write_port.sv */
module host_write_port (
  input  logic                        bus_clk,
  input  logic                        rst,
  input  logic                        wr_wren,
  input  host_bridge_pkg::host_word_t wr_data,
  input  logic                        wr_open,
  output logic                        wr_full,
  input  logic                        pc_msg_ack,
  output host_bridge_pkg::host_word_t pc_msg,
  output logic                        pc_msg_end,
  output logic                        pc_msg_empty
);
  import host_bridge_pkg::*;

  logic wr_accept;

  // Writes on a closed stream never reach the buffer
  assign wr_accept = wr_wren && wr_open;

  msg_fifo #(
    .depth (WR_FIFO_DEPTH)
  ) u_wr_fifo (
    .bus_clk (bus_clk),
    .rst     (rst),
    .wr_en   (wr_accept),
    .din     (wr_data),
    .rd_en   (pc_msg_ack),
    .dout    (pc_msg),
    .full    (wr_full),
    .empty   (pc_msg_empty)
  );

  // Head word is the batch terminator
  assign pc_msg_end = !pc_msg_empty && (pc_msg == END_MARKER);

endmodule

/* src/msg_handler.sv */
module msg_handler (
  input  logic                        bus_clk,
  input  logic                        rst,
  input  host_bridge_pkg::host_word_t pc_msg,
  input  logic                        pc_msg_end,
  input  logic                        pc_msg_empty,
  output logic                        pc_msg_ack,
  output logic                        loop_wr_en,
  input  logic                        loop_full,
  input  logic                        rd_open,
  output logic                        reply_wr_en,
  output host_bridge_pkg::host_word_t reply_data,
  input  logic                        reply_full,
  output logic                        batch_done
);
  import host_bridge_pkg::*;

  typedef enum logic {
    st_forward,
    st_reply
  } state_t;

  state_t     state;
  msg_count_t count;
  logic       pop;

  // ****************************************
  // Host word pop and echo
  // ****************************************

  // Pop only when the echo has room
  assign pop        = (state == st_forward) && !pc_msg_empty && !loop_full;
  assign pc_msg_ack = pop;
  assign loop_wr_en = pop;

  // ****************************************
  // Count reply
  // ****************************************

  // Held until reply space exists and the host has the stream open
  assign reply_wr_en = (state == st_reply) && !reply_full && rd_open;
  assign reply_data  = host_word_t'(count);

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      state      <= st_forward;
      count      <= '0;
      batch_done <= 1'b0;
    end else begin
      case (state)
        st_forward: begin
          if (pop) begin
            batch_done <= 1'b0;
            if (pc_msg_end) begin
              state <= st_reply;
            end else begin
              count <= count + 1'b1;
            end
          end
        end
        st_reply: begin
          if (reply_wr_en) begin
            // Next batch starts from zero
            count      <= '0;
            batch_done <= 1'b1;
            state      <= st_forward;
          end
        end
        default: begin
          state <= st_forward;
        end
      endcase
    end
  end

endmodule

/* src/host_read_port.sv */
module host_read_port (
  input  logic                        bus_clk,
  input  logic                        rst,
  input  logic                        loop_wr_en,
  input  host_bridge_pkg::host_word_t pc_msg,
  output logic                        loop_full,
  input  logic                        loop_rden,
  output host_bridge_pkg::host_word_t loop_data,
  output logic                        loop_empty,
  output logic                        loop_eof,
  input  logic                        reply_wr_en,
  input  host_bridge_pkg::host_word_t reply_data,
  output logic                        reply_full,
  input  logic                        rd_rden,
  output host_bridge_pkg::host_word_t rd_data,
  output logic                        rd_empty,
  output logic                        rd_eof,
  input  logic                        batch_done,
  input  logic                        wr_open,
  input  logic                        pc_msg_empty
);
  import host_bridge_pkg::*;

  // ****************************************
  // Outbound buffers
  // ****************************************

  // Echo of each popped host word
  msg_fifo #(
    .depth (LOOP_FIFO_DEPTH)
  ) u_loop_fifo (
    .bus_clk (bus_clk),
    .rst     (rst),
    .wr_en   (loop_wr_en),
    .din     (pc_msg),
    .rd_en   (loop_rden),
    .dout    (loop_data),
    .full    (loop_full),
    .empty   (loop_empty)
  );

  // Batch count replies
  msg_fifo #(
    .depth (RD_FIFO_DEPTH)
  ) u_reply_fifo (
    .bus_clk (bus_clk),
    .rst     (rst),
    .wr_en   (reply_wr_en),
    .din     (reply_data),
    .rd_en   (rd_rden),
    .dout    (rd_data),
    .full    (reply_full),
    .empty   (rd_empty)
  );

  // ****************************************
  // End-of-file flags
  // ****************************************
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      rd_eof   <= 1'b0;
      loop_eof <= 1'b0;
    end else begin
      // Reply of the last batch has been taken by the host
      rd_eof   <= batch_done && rd_empty;
      // Stream closed and nothing left anywhere on the echo path
      loop_eof <= !wr_open && pc_msg_empty && loop_empty;
    end
  end

endmodule

/* src/host_bridge_top.sv */
module host_bridge_top (
  input  logic                        bus_clk,
  input  logic                        rst,
  input  logic                        wr_wren,
  input  host_bridge_pkg::host_word_t wr_data,
  input  logic                        wr_open,
  output logic                        wr_full,
  input  logic                        rd_rden,
  input  logic                        rd_open,
  output host_bridge_pkg::host_word_t rd_data,
  output logic                        rd_empty,
  output logic                        rd_eof,
  input  logic                        loop_rden,
  output host_bridge_pkg::host_word_t loop_data,
  output logic                        loop_empty,
  output logic                        loop_eof
);
  import host_bridge_pkg::*;

  // Write side to handler
  host_word_t pc_msg;
  logic       pc_msg_end;
  logic       pc_msg_empty;
  logic       pc_msg_ack;

  // Handler to read side
  logic       loop_wr_en;
  logic       loop_full;
  logic       reply_wr_en;
  host_word_t reply_data;
  logic       reply_full;
  logic       batch_done;

  host_write_port u_write_port (
    .bus_clk      (bus_clk),
    .rst          (rst),
    .wr_wren      (wr_wren),
    .wr_data      (wr_data),
    .wr_open      (wr_open),
    .wr_full      (wr_full),
    .pc_msg_ack   (pc_msg_ack),
    .pc_msg       (pc_msg),
    .pc_msg_end   (pc_msg_end),
    .pc_msg_empty (pc_msg_empty)
  );

  msg_handler u_handler (
    .bus_clk      (bus_clk),
    .rst          (rst),
    .pc_msg       (pc_msg),
    .pc_msg_end   (pc_msg_end),
    .pc_msg_empty (pc_msg_empty),
    .pc_msg_ack   (pc_msg_ack),
    .loop_wr_en   (loop_wr_en),
    .loop_full    (loop_full),
    .rd_open      (rd_open),
    .reply_wr_en  (reply_wr_en),
    .reply_data   (reply_data),
    .reply_full   (reply_full),
    .batch_done   (batch_done)
  );

  host_read_port u_read_port (
    .bus_clk      (bus_clk),
    .rst          (rst),
    .loop_wr_en   (loop_wr_en),
    .pc_msg       (pc_msg),
    .loop_full    (loop_full),
    .loop_rden    (loop_rden),
    .loop_data    (loop_data),
    .loop_empty   (loop_empty),
    .loop_eof     (loop_eof),
    .reply_wr_en  (reply_wr_en),
    .reply_data   (reply_data),
    .reply_full   (reply_full),
    .rd_rden      (rd_rden),
    .rd_data      (rd_data),
    .rd_empty     (rd_empty),
    .rd_eof       (rd_eof),
    .batch_done   (batch_done),
    .wr_open      (wr_open),
    .pc_msg_empty (pc_msg_empty)
  );

endmodule

/* tb/tb_clk_gen.sv */
module tb_clk_gen (
  output logic bus_clk,
  output logic rst
);

  // Period of 8 time units
  initial begin
    bus_clk = 1'b0;
    forever #4 bus_clk = ~bus_clk;
  end

  // Reset held over the first 3 rising edges
  initial begin
    rst = 1'b1;
    repeat (3) @(posedge bus_clk);
    rst <= 1'b0;
  end

endmodule

/* tb/tb_host_bridge.sv */
module tb_host_bridge;
  import host_bridge_pkg::*;

  typedef struct {
    int   n_words;
    logic read_during;
    logic rd_open;
    logic expect_full;
  } batch_t;

  typedef enum {
    reset_done,
    wr_space,
    loop_drained,
    reply_ready,
    rd_eof_high,
    rd_eof_low,
    loop_eof_high
  } wait_cond_t;

  localparam int timeout_cycles = 300;

  // Data words, loopback read while writing, rd_open, wr_full expected
  batch_t batch_rows [5] = '{
    '{5, 1'b1, 1'b1, 1'b0},
    '{0, 1'b1, 1'b1, 1'b0},
    '{40, 1'b0, 1'b1, 1'b1},
    '{7, 1'b1, 1'b0, 1'b0},
    '{12, 1'b1, 1'b1, 1'b0}
  };

  logic       bus_clk;
  logic       rst;
  logic       wr_wren;
  host_word_t wr_data;
  logic       wr_open;
  logic       wr_full;
  logic       rd_rden;
  logic       rd_open;
  host_word_t rd_data;
  logic       rd_empty;
  logic       rd_eof;
  logic       loop_rden = 1'b0;
  host_word_t loop_data;
  logic       loop_empty;
  logic       loop_eof;

  logic       loop_read_en;
  logic       saw_full;
  integer     seed = 32'hd8c7;
  host_word_t exp_q [$];

  tb_clk_gen u_clk_gen (
    .bus_clk (bus_clk),
    .rst     (rst)
  );

  host_bridge_top u_dut (
    .bus_clk    (bus_clk),
    .rst        (rst),
    .wr_wren    (wr_wren),
    .wr_data    (wr_data),
    .wr_open    (wr_open),
    .wr_full    (wr_full),
    .rd_rden    (rd_rden),
    .rd_open    (rd_open),
    .rd_data    (rd_data),
    .rd_empty   (rd_empty),
    .rd_eof     (rd_eof),
    .loop_rden  (loop_rden),
    .loop_data  (loop_data),
    .loop_empty (loop_empty),
    .loop_eof   (loop_eof)
  );

  // ****************************************
  // Checks and waits
  // ****************************************
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input host_word_t got, input host_word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  function automatic logic cond_met(input wait_cond_t c);
    case (c)
      reset_done:    return rst === 1'b0;
      wr_space:      return wr_full === 1'b0;
      loop_drained:  return exp_q.size() == 0;
      reply_ready:   return rd_empty === 1'b0;
      rd_eof_high:   return rd_eof === 1'b1;
      rd_eof_low:    return rd_eof === 1'b0;
      loop_eof_high: return loop_eof === 1'b1;
      default:       return 1'b0;
    endcase
  endfunction

  task automatic wait_until(input wait_cond_t c);
    int cycles;
    cycles = 0;
    while (!cond_met(c)) begin
      if (cycles == timeout_cycles) begin
        abort_run($sformatf("Timeout while waiting for %s", c.name()));
      end
      cycles++;
      @(negedge bus_clk);
    end
  endtask

  // Loopback reader, pops and checks one word per cycle when enabled
  always @(negedge bus_clk) begin
    loop_rden = 1'b0;
    if (loop_eof === 1'b1 && loop_empty !== 1'b1) begin
      abort_run("loop_eof is high while loopback data is still pending");
    end
    if (!rst && loop_read_en && loop_empty === 1'b0) begin
      if (exp_q.size() == 0) begin
        abort_run("Unexpected extra word on the loopback channel");
      end
      check_word("loop_data", loop_data, exp_q.pop_front());
      loop_rden = 1'b1;
    end
  end

  // ****************************************
  // Stimulus
  // ****************************************
  initial begin
    host_word_t w;
    msg_count_t exp_count;
    wr_wren      = 1'b0;
    wr_data      = '0;
    wr_open      = 1'b1;
    rd_rden      = 1'b0;
    rd_open      = 1'b1;
    loop_read_en = 1'b0;
    saw_full     = 1'b0;
    @(negedge bus_clk);
    wait_until(reset_done);
    check_flag("wr_full", wr_full, 1'b0);
    check_flag("rd_empty", rd_empty, 1'b1);
    check_flag("loop_empty", loop_empty, 1'b1);
    check_flag("rd_eof", rd_eof, 1'b0);
    check_flag("loop_eof", loop_eof, 1'b0);

    foreach (batch_rows[r]) begin
      rd_open      = batch_rows[r].rd_open;
      loop_read_en = batch_rows[r].read_during;
      saw_full     = 1'b0;
      for (int i = 0; i <= batch_rows[r].n_words; i++) begin
        w = $random(seed);
        // Data words must never look like the marker
        if (w == END_MARKER) begin
          w = '0;
        end
        if (i == batch_rows[r].n_words) begin
          w = END_MARKER;
        end
        @(negedge bus_clk);
        wr_wren = 1'b0;
        if (wr_full) begin
          saw_full     = 1'b1;
          loop_read_en = 1'b1;
        end
        wait_until(wr_space);
        wr_wren = 1'b1;
        wr_data = w;
        exp_q.push_back(w);
      end
      @(negedge bus_clk);
      wr_wren      = 1'b0;
      loop_read_en = 1'b1;
      wait_until(loop_drained);
      check_flag("wr_full seen", saw_full, batch_rows[r].expect_full);
      wait_until(rd_eof_low);

      // Reply must stay back while the read stream is closed
      if (!batch_rows[r].rd_open) begin
        repeat (8) @(negedge bus_clk);
        check_flag("rd_empty", rd_empty, 1'b1);
        rd_open = 1'b1;
      end
      wait_until(reply_ready);
      check_flag("rd_eof", rd_eof, 1'b0);
      exp_count = msg_count_t'(batch_rows[r].n_words);
      check_word("rd_data", rd_data, host_word_t'(exp_count));
      rd_rden = 1'b1;
      @(negedge bus_clk);
      rd_rden = 1'b0;
      check_flag("rd_empty", rd_empty, 1'b1);
      wait_until(rd_eof_high);
    end

    // Close the stream
    wr_open = 1'b0;
    wait_until(loop_eof_high);
    check_flag("loop_empty", loop_empty, 1'b1);
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* all.f */
src/host_bridge_pkg.sv
src/msg_fifo.sv
src/host_write_port.sv
src/msg_handler.sv
src/host_read_port.sv
src/host_bridge_top.sv
tb/tb_clk_gen.sv
tb/tb_host_bridge.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := tb_host_bridge
FLIST     := all.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q '^PASS: all tests$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
